//--- source/game_pkg.sv
// game movement definitions
`default_nettype none

package game_pkg;

    // key codes from the keyboard decoder
    typedef enum logic [3:0] {
        key_none = 4'd0,                    // no action
        key_w    = 4'd1,                    // jump
        key_a    = 4'd2,                    // walk left
        key_d    = 4'd3                     // walk right
    } key_code_t;

    typedef logic [10:0] xpos_t;            // horizontal pixel position
    typedef logic [9:0]  ypos_t;            // vertical pixel position, grows downward
    typedef logic [15:0] map_adr_t;         // {row[6:0], col[8:0]}
    typedef logic [6:0]  map_row_t;         // map row field of map_adr_t
    typedef logic [8:0]  map_col_t;         // map column field of map_adr_t
    typedef logic [3:0]  pixel_t;           // terrain pixel, 0 is solid
    typedef logic [5:0]  jump_t;            // remaining upward speed per step

    // player position as seen by the sprite logic
    typedef struct packed {
        xpos_t x;
        ypos_t y;
    } player_pos_t;

    // vertical limits
    localparam ypos_t y_floor    = 10'd448; // lowest y, also the reset y
    localparam ypos_t y_ceiling  = 10'd20;  // a jump needs y above this
    // horizontal limits
    localparam xpos_t x_reset    = 11'd512;
    localparam xpos_t x_step     = 11'd4;   // pixels per step
    localparam xpos_t x_max      = 11'd1020;

    // jump profile
    localparam jump_t jump_start = 6'd15;   // speed right after takeoff
    localparam jump_t jump_min   = 6'd8;    // below this the jump is over
    localparam ypos_t fall_step  = 10'd2;   // gravity per step

    // step pacing
    localparam int step_cycles = 8;         // timer counts per step
    localparam int timer_w     = $clog2(step_cycles + 1);
    typedef logic [timer_w-1:0] timer_t;

    // terrain rule
    localparam map_row_t feet_row_ofs    = 7'd2;   // map rows from sprite top to feet
    localparam map_row_t ground_row_low  = 7'd114; // floor level
    localparam map_row_t ground_row_high = 7'd100; // ledge level
    localparam pixel_t   sky_pixel       = 4'hb;

endpackage

`default_nettype wire

//--- source/collision_map.sv
// terrain collision map
`timescale 1ns/10ps
`default_nettype none

module collision_map
    import game_pkg::*;
(
    input  logic     clk,
    input  map_adr_t adr,                   // {row, col}
    output pixel_t   pixel                  // valid one cycle after adr
);

    map_row_t row;
    map_col_t col;
    map_row_t ground_row;                   // first solid row in this column
    logic     solid;

    assign row = adr[15:9];
    assign col = adr[8:0];

    // every other 32 column band carries a raised ledge
    always_comb begin
        if (col[5]) begin
            ground_row = ground_row_high;   // ledge band
        end else begin
            ground_row = ground_row_low;    // plain floor
        end
    end

    assign solid = (row >= ground_row);     // ground and everything below it

    // registered read, like a block ROM
    always_ff @(posedge clk) begin
        if (solid) begin
            pixel <= '0;
        end else begin
            pixel <= sky_pixel;
        end
    end

endmodule

`default_nettype wire

//--- source/player_control_x.sv
// player horizontal motion control
`timescale 1ns/10ps
`default_nettype none

module player_control_x
    import game_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  key_code_t key,                  // sampled with the step strobe
    input  logic      step,                 // end of step from the vertical control
    output xpos_t     x
);

    xpos_t x_nxt;
    logic  can_left;                        // room for one step to the left
    logic  can_right;                       // room for one step to the right

    assign can_left  = (x >= x_step);
    assign can_right = (x <= x_max - x_step);

    always_comb begin
        x_nxt = x;                          // hold between strobes
        if (step) begin
            case (key)
                key_a: begin
                    if (can_left) begin
                        x_nxt = x - x_step;
                    end
                end
                key_d: begin
                    if (can_right) begin
                        x_nxt = x + x_step;
                    end
                end
                default: begin
                    x_nxt = x;              // jump and none leave x alone
                end
            endcase
        end
    end

    // new x shows up in the cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            x <= x_reset;
        end else begin
            x <= x_nxt;
        end
    end

endmodule

`default_nettype wire

//--- source/player_control_y.sv
// player vertical motion control
`timescale 1ns/10ps
`default_nettype none

module player_control_y
    import game_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  key_code_t key,
    input  xpos_t     x,
    input  pixel_t    pixel,                // map pixel under the feet
    output ypos_t     y,
    output map_adr_t  pixel_adr,
    output logic      step                  // one cycle at the end of each step
);

    typedef enum logic [1:0] {
        idle = 2'b00,                       // decide jump or gravity
        up   = 2'b01,                       // jump taken
        down = 2'b11,                       // gravity applied
        tim  = 2'b10                        // wait out the step period
    } state_t;

    state_t      state, state_nxt;
    timer_t      timer, timer_nxt;
    jump_t       jump, jump_nxt;
    ypos_t       y_nxt;
    jump_t       jump_dec;                  // jump speed after one step of decay
    logic [10:0] y_sum;                     // gravity result, bit 10 is the sign
    logic        airborne;                  // nothing solid under the feet
    logic        timer_done;
    map_row_t    feet_row;
    map_col_t    feet_col;

    assign timer_done = (timer == timer_t'(step_cycles));
    assign step       = (state == tim) && timer_done; // last cycle of tim

    // gravity step, used when no jump key is seen
    always_comb begin
        jump_dec = (jump > jump_min) ? jump - 6'd1 : '0;    // decay, then stop
        airborne = (y < y_floor) && (pixel != '0);
        if (airborne) begin
            y_sum = {1'b0, y} + {1'b0, fall_step} - {5'b0, jump_dec};
        end else begin
            y_sum = {1'b0, y} - {5'b0, jump_dec};           // standing, only the jump
        end
    end

    // next state and motion update
    always_comb begin
        state_nxt = state;
        timer_nxt = timer;
        jump_nxt  = jump;
        y_nxt     = y;
        case (state)
            idle: begin                     // key sampled here
                if (key == key_w) begin
                    state_nxt = up;
                    if (y > y_ceiling) begin
                        y_nxt    = y - 10'd1;   // takeoff
                        jump_nxt = jump_start;
                    end else begin
                        jump_nxt = '0;      // too high, no new jump
                    end
                end else begin
                    state_nxt = down;
                    jump_nxt  = jump_dec;
                    y_nxt     = y_sum[10] ? '0 : y_sum[9:0]; // clamp at top of screen
                end
            end
            up, down: begin
                state_nxt = tim;
                timer_nxt = '0;
            end
            tim: begin
                if (timer_done) begin
                    state_nxt = idle;
                    timer_nxt = '0;
                end else begin
                    timer_nxt = timer + timer_t'(1);
                end
            end
            default: begin
                state_nxt = idle;
                timer_nxt = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            timer <= '0;
            jump  <= '0;
            y     <= y_floor;
        end else begin
            state <= state_nxt;
            timer <= timer_nxt;
            jump  <= jump_nxt;
            y     <= y_nxt;
        end
    end

    // map address of the feet, one map cell per 4x4 pixels
    assign feet_row = map_row_t'(y[9:2]) + feet_row_ofs;
    assign feet_col = x[10:2];

    always_ff @(posedge clk) begin
        pixel_adr <= {feet_row, feet_col};  // refreshed every cycle
    end

endmodule

`default_nettype wire

//--- source/player_ctl_top.sv
// player movement top level
`timescale 1ns/10ps
`default_nettype none

module player_ctl_top
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  key_code_t   key,                // decoded key, held by the caller
    output player_pos_t pos,
    output logic        step                // one strobe per game step
);

    xpos_t    x;
    ypos_t    y;
    map_adr_t pixel_adr;                    // feet address into the map
    pixel_t   pixel;                        // map answer, one cycle later

    // vertical motion also paces the step
    player_control_y i_control_y (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .x         (x),
        .pixel     (pixel),
        .y         (y),
        .pixel_adr (pixel_adr),
        .step      (step)
    );

    player_control_x i_control_x (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .step (step),
        .x    (x)
    );

    collision_map i_map (
        .clk   (clk),
        .adr   (pixel_adr),
        .pixel (pixel)
    );

    assign pos.x = x;
    assign pos.y = y;

endmodule

`default_nettype wire

//--- testbench/tb_player_ctl.sv
// player movement testbench
`timescale 1ns/10ps
`default_nettype none

module tb_player_ctl
    import game_pkg::*;
();

    localparam int n_rows       = 28;               // rows in the stimulus table
    localparam int random_steps = 40;               // random keys after the table
    localparam int step_len     = step_cycles + 3;  // cycles from strobe to strobe

    typedef struct packed {
        key_code_t   key;                   // key held for the whole row
        logic [15:0] steps;                 // number of game steps in the row
    } stim_t;

    logic        clk;
    logic        rst;
    key_code_t   key;
    player_pos_t pos;
    logic        step;

    stim_t stim_table [n_rows];
    int    seed;
    int    cycle_count = 0;
    int    timeout_limit;
    int    m_x;                             // model x
    int    m_y;                             // model y
    int    m_jump;                          // model jump speed
    int    m_x_lag;                         // x behind the map pixel at the next decision

    player_ctl_top i_dut (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .pos  (pos),
        .step (step)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period
    end

    // run limit from the number of steps
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("run timed out waiting for a step strobe after %0d cycles", cycle_count);
            $display("Test failed");
            $fatal(1);
        end
    end

    // terrain rule where ground reads 0
    function automatic pixel_t map_pixel(input int y, input int x);
        int row;
        int col;
        int ground;
        row = ((y / 4) + 2) % 128;          // feet row in 7 bits
        col = (x / 4) % 512;
        if (((col / 32) % 2) == 1) begin
            ground = int'(ground_row_high); // ledge band
        end else begin
            ground = int'(ground_row_low);
        end
        if (row >= ground) begin
            map_pixel = '0;
        end else begin
            map_pixel = sky_pixel;
        end
    endfunction

    task automatic fill_table();
        int i;
        stim_table[0] = '{key_none, 16'd3};     // stand on the floor
        stim_table[1] = '{key_w, 16'd1};        // single jump
        stim_table[2] = '{key_none, 16'd40};    // rise, fall and land
        for (i = 0; i < 10; i++) begin          // climb with repeated jumps up to y 0
            stim_table[3 + 2 * i] = '{key_w, 16'd1};
            stim_table[4 + 2 * i] = '{key_none, 16'd5};
        end
        stim_table[23] = '{key_d, 16'd240};     // fall while walking right into x_max
        stim_table[24] = '{key_a, 16'd300};     // off the ledge and down to x 0
        stim_table[25] = '{key_d, 16'd24};
        stim_table[26] = '{key_w, 16'd1};
        stim_table[27] = '{key_d, 16'd30};      // land on the ledge band mid-fall
    endtask

    function automatic int total_steps();
        int i;
        int sum;
        sum = random_steps;
        for (i = 0; i < n_rows; i++) begin
            sum = sum + int'(stim_table[i].steps);
        end
        total_steps = sum;
    endfunction

    // vertical rules with the key taken at the idle decision
    task automatic model_y(input key_code_t k);
        int next_y;
        if (k == key_w) begin
            if (m_y > int'(y_ceiling)) begin
                m_y    = m_y - 1;           // takeoff
                m_jump = int'(jump_start);
            end else begin
                m_jump = 0;
            end
        end else begin
            if (m_jump > int'(jump_min)) begin
                m_jump = m_jump - 1;
            end else begin
                m_jump = 0;
            end
            if (m_y < int'(y_floor) && map_pixel(m_y, m_x_lag) != '0) begin
                next_y = m_y + int'(fall_step) - m_jump;    // in the air
            end else begin
                next_y = m_y - m_jump;
            end
            if (next_y < 0) begin
                m_y = 0;                    // top of screen
            end else begin
                m_y = next_y;
            end
        end
    endtask

    // horizontal rules with the key taken at the strobe
    task automatic model_x(input key_code_t k);
        m_x_lag = m_x;                      // map address still built from this x
        if (k == key_a && m_x >= int'(x_step)) begin
            m_x = m_x - int'(x_step);
        end else if (k == key_d && m_x <= int'(x_max) - int'(x_step)) begin
            m_x = m_x + int'(x_step);
        end
    endtask

    task automatic check_x(input xpos_t got, input xpos_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: x %s is %0d, expected %0d", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_y(input ypos_t got, input ypos_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: y %s is %0d, expected %0d", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_step(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: step %s is %b, expected %b", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // one game step entered and left on a falling edge
    task automatic run_step(input key_code_t k);
        int waited;                         // falling edges from key to strobe
        key = k;                            // held through idle and the strobe
        @(negedge clk);
        waited = 1;
        while (step !== 1'b1) begin
            @(negedge clk);
            waited = waited + 1;
        end
        check_cycles(waited, step_len - 1, "falling edges to strobe");
        model_y(k);
        check_y(pos.y, ypos_t'(m_y), "at strobe");
        check_x(pos.x, xpos_t'(m_x), "at strobe");     // x still old here
        model_x(k);
        @(negedge clk);
        check_step(step, 1'b0, "after strobe");         // single cycle strobe
        check_x(pos.x, xpos_t'(m_x), "after strobe");
        check_y(pos.y, ypos_t'(m_y), "after strobe");
    endtask

    initial begin
        int row;
        int n;
        int rnd;
        rst  = 1'b1;
        key  = key_none;
        seed = 32'h1e42;
        fill_table();
        timeout_limit = total_steps() * step_len + 100;
        m_x     = int'(x_reset);
        m_y     = int'(y_floor);
        m_jump  = 0;
        m_x_lag = m_x;
        repeat (8) @(negedge clk);          // 8 reset cycles
        check_step(step, 1'b0, "in reset");
        check_x(pos.x, x_reset, "after reset");
        check_y(pos.y, y_floor, "after reset");
        rst = 1'b0;
        for (row = 0; row < n_rows; row++) begin
            for (n = 0; n < int'(stim_table[row].steps); n++) begin
                run_step(stim_table[row].key);
            end
        end
        for (n = 0; n < random_steps; n++) begin
            rnd = $random(seed);
            run_step(key_code_t'({2'b00, rnd[1:0]}));   // any of the four keys
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
source/game_pkg.sv
source/collision_map.sv
source/player_control_x.sv
source/player_control_y.sv
source/player_ctl_top.sv
testbench/tb_player_ctl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile the player movement testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_player_ctl -f tb.f -o sim_player_ctl \
    || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/sim_player_ctl 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Test passed" && exit 0 || exit 1
